//--- Bender.yml
package:
  name: opening_filter

sources:
  - hw/video_pkg.sv
  - hw/morph_pkg.sv
  - hw/video_if.sv
  - hw/mask_threshold.sv
  - hw/window3x3.sv
  - hw/morph_stage.sv
  - hw/opening_overlay.sv
  - hw/opening_filter_top.sv
  - target: test
    files:
      - test/tb_opening_filter.sv

//--- filelist.f
hw/video_pkg.sv
hw/morph_pkg.sv
hw/video_if.sv
hw/mask_threshold.sv
hw/window3x3.sv
hw/morph_stage.sv
hw/opening_overlay.sv
hw/opening_filter_top.sv
test/tb_opening_filter.sv

//--- hw/mask_threshold.sv
module mask_threshold (
    input  logic                clk,
    input  logic                rst,
    input  logic                de,
    input  logic                hsync,
    input  logic                vsync,
    input  video_pkg::chan_t    red,
    input  video_pkg::chan_t    green,
    input  video_pkg::chan_t    blue,
    video_if.source             vid
);

    logic hit;

    // Only active pixels may be marked, so blanking never enters the mask.
    assign hit = de && (red >= video_pkg::red_threshold);

    always_ff @(posedge clk) begin
        if (rst) begin
            vid.de    <= 1'b0;
            vid.hsync <= 1'b0;
            vid.vsync <= 1'b0;
            vid.mask  <= 1'b0;
        end else begin
            vid.de    <= de;
            vid.hsync <= hsync;
            vid.vsync <= vsync;
            vid.mask  <= hit;
        end
    end

    // Color rides along for the overlay.
    always_ff @(posedge clk) begin
        vid.pixel.red   <= red;
        vid.pixel.green <= green;
        vid.pixel.blue  <= blue;
    end

endmodule

//--- hw/morph_pkg.sv
package morph_pkg;

    // ------------------------------------------------------------
    // Morphology opcodes
    // ------------------------------------------------------------
    typedef enum logic {
        morph_erode  = 1'b0,                        // AND over the window.
        morph_dilate = 1'b1                         // OR over the window.
    } morph_op_e;

    // ------------------------------------------------------------
    // Window geometry and latencies
    // ------------------------------------------------------------
    localparam int win_size = 3;                    // Kernel is win_size x win_size.
    localparam int win_taps = win_size * win_size;

    // Center sits one line plus one pixel behind the newest sample.
    localparam int center_delay = video_pkg::line_period + 1;

    localparam int stage_latency = center_delay + 1;    // Window plus result register.

    // Threshold register, two stages, then the overlay register.
    localparam int opening_latency = 2 * stage_latency + 2;

endpackage

//--- hw/morph_stage.sv
module morph_stage #(
    parameter morph_pkg::morph_op_e op = morph_pkg::morph_erode
) (
    input  logic    clk,
    input  logic    rst,
    video_if.sink   vid_in,
    video_if.source vid_out
);

    logic [morph_pkg::win_taps-1:0] taps;
    logic [2:0]                     center;
    logic                           result;

    window3x3 window3x3_inst (
        .clk    (clk),
        .rst    (rst),
        .vid    (vid_in),
        .taps   (taps),
        .center (center)
    );

    // Erosion keeps a pixel only if the whole window is set, dilation if any tap is.
    always_comb begin
        case (op)
            morph_pkg::morph_erode:  result = &taps;
            morph_pkg::morph_dilate: result = |taps;
            default:                 result = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vid_out.de    <= 1'b0;
            vid_out.hsync <= 1'b0;
            vid_out.vsync <= 1'b0;
            vid_out.mask  <= 1'b0;
        end else begin
            vid_out.de    <= center[0];
            vid_out.hsync <= center[1];
            vid_out.vsync <= center[2];
            vid_out.mask  <= result & center[0];    // No mask outside the active area.
        end
    end

    // Color is taken from the threshold stream by the overlay.
    assign vid_out.pixel = '0;

endmodule

//--- hw/opening_filter_top.sv
module opening_filter_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                de_in,
    input  logic                hsync_in,
    input  logic                vsync_in,
    input  video_pkg::chan_t    red_in,
    input  video_pkg::chan_t    green_in,
    input  video_pkg::chan_t    blue_in,
    output logic                de_out,
    output logic                hsync_out,
    output logic                vsync_out,
    output video_pkg::chan_t    red_out,
    output video_pkg::chan_t    green_out,
    output video_pkg::chan_t    blue_out
);

    video_if threshold_if ();
    video_if eroded_if ();
    video_if opened_if ();

    mask_threshold mask_threshold_inst (
        .clk   (clk),
        .rst   (rst),
        .de    (de_in),
        .hsync (hsync_in),
        .vsync (vsync_in),
        .red   (red_in),
        .green (green_in),
        .blue  (blue_in),
        .vid   (threshold_if)
    );

    // Opening is erosion followed by dilation.
    morph_stage #(.op(morph_pkg::morph_erode)) erode_inst (
        .clk     (clk),
        .rst     (rst),
        .vid_in  (threshold_if),
        .vid_out (eroded_if)
    );

    morph_stage #(.op(morph_pkg::morph_dilate)) dilate_inst (
        .clk     (clk),
        .rst     (rst),
        .vid_in  (eroded_if),
        .vid_out (opened_if)
    );

    opening_overlay opening_overlay_inst (
        .clk    (clk),
        .rst    (rst),
        .orig   (threshold_if),
        .opened (opened_if),
        .de     (de_out),
        .hsync  (hsync_out),
        .vsync  (vsync_out),
        .red    (red_out),
        .green  (green_out),
        .blue   (blue_out)
    );

endmodule

//--- hw/opening_overlay.sv
module opening_overlay (
    input  logic                clk,
    input  logic                rst,
    video_if.sink               orig,
    video_if.sink               opened,
    output logic                de,
    output logic                hsync,
    output logic                vsync,
    output video_pkg::chan_t    red,
    output video_pkg::chan_t    green,
    output video_pkg::chan_t    blue
);

    // ------------------------------------------------------------
    // Color delay matching erode plus dilate
    // ------------------------------------------------------------
    video_pkg::pixel_t pix_dly [2*morph_pkg::stage_latency];
    video_pkg::pixel_t pix_aligned;

    always_ff @(posedge clk) begin
        pix_dly[0] <= orig.pixel;
        for (int i = 1; i < 2*morph_pkg::stage_latency; i++) begin
            pix_dly[i] <= pix_dly[i-1];
        end
    end

    assign pix_aligned = pix_dly[2*morph_pkg::stage_latency-1];

    // ------------------------------------------------------------
    // Repaint and output register
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (opened.mask) begin
            red   <= video_pkg::chan_max;           // Opened region goes white.
            green <= video_pkg::chan_max;
            blue  <= video_pkg::chan_max;
        end else begin
            red   <= pix_aligned.red;
            green <= pix_aligned.green;
            blue  <= pix_aligned.blue;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            de    <= 1'b0;
            hsync <= 1'b0;
            vsync <= 1'b0;
        end else begin
            de    <= opened.de;
            hsync <= opened.hsync;
            vsync <= opened.vsync;
        end
    end

endmodule

//--- hw/video_if.sv
interface video_if;

    logic               de;                         // Active pixel.
    logic               hsync;
    logic               vsync;
    logic               mask;                       // Detection bit for this pixel.
    video_pkg::pixel_t  pixel;

    modport source (
        output de,
        output hsync,
        output vsync,
        output mask,
        output pixel
    );

    modport sink (
        input de,
        input hsync,
        input vsync,
        input mask,
        input pixel
    );

endinterface

//--- hw/video_pkg.sv
package video_pkg;

    // ------------------------------------------------------------
    // Pixel and channel definitions
    // ------------------------------------------------------------
    localparam int chan_w = 8;                      // Bits per color channel.

    typedef logic [chan_w-1:0] chan_t;

    localparam chan_t chan_max = {chan_w{1'b1}};    // Full scale, used for white.

    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } pixel_t;

    // ------------------------------------------------------------
    // Raster and detection constants
    // ------------------------------------------------------------
    localparam int line_period = 24;                // Clocks per line, blanking included.

    // Red level at or above which a pixel is marked.
    localparam chan_t red_threshold = 8'd255;

endpackage

//--- hw/window3x3.sv
module window3x3 (
    input  logic                            clk,
    input  logic                            rst,
    video_if.sink                           vid,
    output logic [morph_pkg::win_taps-1:0]  taps,
    output logic [2:0]                      center      // {vsync, hsync, de}.
);

    // ------------------------------------------------------------
    // Line buffers
    // ------------------------------------------------------------
    // Bit k holds the sample from k+1 clocks ago, so the top bit is one
    // full line old.
    logic [video_pkg::line_period-1:0] lb1_mask;
    logic [video_pkg::line_period-1:0] lb1_de;
    logic [video_pkg::line_period-1:0] lb2_mask;
    logic [video_pkg::line_period-1:0] lb2_de;

    always_ff @(posedge clk) begin
        lb1_mask <= {lb1_mask[video_pkg::line_period-2:0], vid.mask};
        lb2_mask <= {lb2_mask[video_pkg::line_period-2:0],
                     lb1_mask[video_pkg::line_period-1]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lb1_de <= '0;
            lb2_de <= '0;
        end else begin
            lb1_de <= {lb1_de[video_pkg::line_period-2:0], vid.de};
            lb2_de <= {lb2_de[video_pkg::line_period-2:0],
                       lb1_de[video_pkg::line_period-1]};
        end
    end

    // ------------------------------------------------------------
    // Row shift registers
    // ------------------------------------------------------------
    // Row 0 is the incoming line, row 1 the center line, row 2 the line above.
    logic [2:0] head_mask;
    logic [2:0] head_de;
    logic [morph_pkg::win_size-2:0] row_mask [3];
    logic [morph_pkg::win_size-2:0] row_de   [3];

    assign head_mask[0] = vid.mask;
    assign head_de[0]   = vid.de;
    assign head_mask[1] = lb1_mask[video_pkg::line_period-1];
    assign head_de[1]   = lb1_de[video_pkg::line_period-1];
    assign head_mask[2] = lb2_mask[video_pkg::line_period-1];
    assign head_de[2]   = lb2_de[video_pkg::line_period-1];

    always_ff @(posedge clk) begin
        for (int r = 0; r < 3; r++) begin
            row_mask[r] <= {row_mask[r][0], head_mask[r]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < 3; r++) begin
                row_de[r] <= '0;
            end
        end else begin
            for (int r = 0; r < 3; r++) begin
                row_de[r] <= {row_de[r][0], head_de[r]};
            end
        end
    end

    // Blanking reads as zero, which pads all four frame edges.
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            taps[r*3]     = head_mask[r] & head_de[r];
            taps[r*3 + 1] = row_mask[r][0] & row_de[r][0];
            taps[r*3 + 2] = row_mask[r][1] & row_de[r][1];
        end
    end

    // ------------------------------------------------------------
    // Sync delay to the window center
    // ------------------------------------------------------------
    logic [morph_pkg::center_delay-1:0] hsync_dly;
    logic [morph_pkg::center_delay-1:0] vsync_dly;

    always_ff @(posedge clk) begin
        if (rst) begin
            hsync_dly <= '0;
            vsync_dly <= '0;
        end else begin
            hsync_dly <= {hsync_dly[morph_pkg::center_delay-2:0], vid.hsync};
            vsync_dly <= {vsync_dly[morph_pkg::center_delay-2:0], vid.vsync};
        end
    end

    assign center[0] = row_de[1][0];                // Middle tap of the center row.
    assign center[1] = hsync_dly[morph_pkg::center_delay-1];
    assign center[2] = vsync_dly[morph_pkg::center_delay-1];

endmodule

//--- test/tb_opening_filter.sv
module tb_opening_filter;

    localparam int act_w = 16;
    localparam int act_h = 8;
    localparam int blank_lines = 2;
    localparam int hsync_len = 4;
    localparam int n_frames = 5;
    localparam int frame_clocks = n_frames * (act_h + blank_lines) * video_pkg::line_period;
    localparam int cycle_limit = frame_clocks + morph_pkg::opening_latency + 100;

    typedef struct packed {
        logic              de;
        logic              hs;
        logic              vs;
        logic              masked;                  // Input red was at full scale.
        video_pkg::pixel_t pix;                     // Expected output color.
    } check_t;

    logic              clk;
    logic              rst;
    logic              de_in;
    logic              hsync_in;
    logic              vsync_in;
    video_pkg::chan_t  red_in;
    video_pkg::chan_t  green_in;
    video_pkg::chan_t  blue_in;
    logic              de_out;
    logic              hsync_out;
    logic              vsync_out;
    video_pkg::chan_t  red_out;
    video_pkg::chan_t  green_out;
    video_pkg::chan_t  blue_out;

    video_pkg::pixel_t exp_pix;
    logic              exp_masked;

    video_pkg::chan_t  red_mem   [act_h][act_w];
    video_pkg::chan_t  green_mem [act_h][act_w];
    video_pkg::chan_t  blue_mem  [act_h][act_w];
    logic              opened_ref [act_h][act_w];

    check_t            pending [$];
    integer            seed;
    int                cycle;
    int                value_errors;
    int                other_errors;
    int                active_sent;
    int                active_checked;
    int                white_seen;
    int                removed_seen;

    opening_filter_top opening_filter_top_inst (
        .clk       (clk),
        .rst       (rst),
        .de_in     (de_in),
        .hsync_in  (hsync_in),
        .vsync_in  (vsync_in),
        .red_in    (red_in),
        .green_in  (green_in),
        .blue_in   (blue_in),
        .de_out    (de_out),
        .hsync_out (hsync_out),
        .vsync_out (vsync_out),
        .red_out   (red_out),
        .green_out (green_out),
        .blue_out  (blue_out)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ------------------------------------------------------------
    // Reference opening
    // ------------------------------------------------------------
    function automatic logic mask_ref(input int x, input int y);
        if (x < 0 || x >= act_w || y < 0 || y >= act_h) begin
            return 1'b0;                            // Zero padding.
        end
        return red_mem[y][x] == 8'hff;
    endfunction

    function automatic logic erode_ref(input int x, input int y);
        logic all_set;
        all_set = (x >= 0 && x < act_w && y >= 0 && y < act_h);
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                all_set = all_set & mask_ref(x + dx, y + dy);
            end
        end
        return all_set;
    endfunction

    function automatic logic dilate_ref(input int x, input int y);
        logic any_set;
        any_set = 1'b0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                any_set = any_set | erode_ref(x + dx, y + dy);
            end
        end
        return any_set;
    endfunction

    task automatic paint(input int x0, input int x1, input int y0, input int y1);
        for (int y = y0; y <= y1; y++) begin
            for (int x = x0; x <= x1; x++) begin
                red_mem[y][x] = 8'hff;
            end
        end
    endtask

    // Kind 0 directed shapes, kind 1 near-threshold block, others random.
    task automatic build_frame(input int kind);
        int r;
        for (int y = 0; y < act_h; y++) begin
            for (int x = 0; x < act_w; x++) begin
                r = $random(seed);
                green_mem[y][x] = r[7:0];
                blue_mem[y][x]  = r[15:8];
                case (kind)
                    0:       red_mem[y][x] = {1'b0, r[22:16]};
                    1:       red_mem[y][x] = 8'hfe;
                    default: red_mem[y][x] = (r[25:24] != 2'b00) ? 8'hff : r[23:16];
                endcase
            end
        end
        if (kind == 0) begin
            paint(1, 1, 1, 1);                      // Isolated pixel.
            paint(3, 4, 0, act_h - 1);              // Two-wide stripe.
            paint(6, 9, 1, 4);
            paint(12, 14, 0, 2);                    // Touches the top edge.
            paint(12, 15, 4, 7);                    // Right and bottom edges.
        end else if (kind == 1) begin
            paint(2, 11, 1, 6);
            red_mem[3][6] = 8'hfe;
        end
        for (int y = 0; y < act_h; y++) begin
            for (int x = 0; x < act_w; x++) begin
                opened_ref[y][x] = dilate_ref(x, y);
            end
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic drive(input logic de, input logic hs, input logic vs, input logic masked,
                         input video_pkg::pixel_t pix, input video_pkg::pixel_t out_pix);
        @(posedge clk);
        #1;
        de_in      = de;
        hsync_in   = hs;
        vsync_in   = vs;
        red_in     = pix.red;
        green_in   = pix.green;
        blue_in    = pix.blue;
        exp_pix    = out_pix;
        exp_masked = masked;
    endtask

    task automatic send_frame();
        video_pkg::pixel_t pix;
        video_pkg::pixel_t out_pix;
        logic              active;
        for (int y = 0; y < act_h + blank_lines; y++) begin
            for (int c = 0; c < video_pkg::line_period; c++) begin
                active  = (y < act_h) && (c < act_w);
                pix     = '0;
                out_pix = '0;
                if (active) begin
                    pix     = {red_mem[y][c], green_mem[y][c], blue_mem[y][c]};
                    out_pix = opened_ref[y][c] ? 24'hffffff : pix;
                    active_sent++;
                end
                drive(active, c >= video_pkg::line_period - hsync_len, y == act_h,
                      active && pix.red == 8'hff, pix, out_pix);
            end
        end
    endtask

    // ------------------------------------------------------------
    // Checking
    // ------------------------------------------------------------
    task automatic report_value(input string name, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
        value_errors++;
        $display("FAILED %s: expected 0x%0h, got 0x%0h at cycle %0d",
                 name, exp_val, act_val, cycle);
    endtask

    assert property (@(posedge clk) rst |=> !(de_out || hsync_out || vsync_out))
        else begin
            value_errors++;
            $display("FAILED {vsync_out,hsync_out,de_out} after reset: expected 0x0, got 0x%0h",
                     {$sampled(vsync_out), $sampled(hsync_out), $sampled(de_out)});
        end

    // Each output cycle matches the input cycle opening_latency clocks earlier.
    always @(posedge clk) begin
        check_t e;
        pending.push_back({de_in, hsync_in, vsync_in, exp_masked, exp_pix});
        if (pending.size() > morph_pkg::opening_latency) begin
            e = pending.pop_front();
            assert (de_out === e.de) else report_value("de_out", e.de, de_out);
            assert (hsync_out === e.hs) else report_value("hsync_out", e.hs, hsync_out);
            assert (vsync_out === e.vs) else report_value("vsync_out", e.vs, vsync_out);
            if (e.de) begin
                assert (red_out === e.pix.red) else report_value("red_out", e.pix.red, red_out);
                assert (green_out === e.pix.green)
                    else report_value("green_out", e.pix.green, green_out);
                assert (blue_out === e.pix.blue)
                    else report_value("blue_out", e.pix.blue, blue_out);
                active_checked++;
                if (e.pix == 24'hffffff) begin
                    white_seen++;
                end else if (e.masked) begin
                    removed_seen++;                 // Dropped by the opening.
                end
            end
        end else if (!rst) begin
            // Pipeline still holds only reset state.
            assert ({vsync_out, hsync_out, de_out} === 3'b000)
                else report_value("{vsync_out,hsync_out,de_out}", 3'b000,
                                  {vsync_out, hsync_out, de_out});
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d of %0d pixels checked",
                     cycle, active_checked, active_sent);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        seed           = 81;
        cycle          = 0;
        value_errors   = 0;
        other_errors   = 0;
        active_sent    = 0;
        active_checked = 0;
        white_seen     = 0;
        removed_seen   = 0;
        rst            = 1'b1;
        de_in          = 1'b0;
        hsync_in       = 1'b0;
        vsync_in       = 1'b0;
        red_in         = '0;
        green_in       = '0;
        blue_in        = '0;
        exp_pix        = '0;
        exp_masked     = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int f = 0; f < n_frames; f++) begin
            build_frame(f);
            send_frame();
        end
        while (active_checked < active_sent) begin
            drive(1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
        end

        assert (white_seen > 0 && removed_seen > 0)
            else begin
                other_errors++;
                $display("Stimulus never produced both a white region and a removed mask pixel");
            end
        $display("Checked %0d pixels: %0d value errors, %0d other errors",
                 active_checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
